/* files.f */
+incdir+.
linemult_pkg.sv
lb_if.sv
pix_if.sv
line_writer.sv
line_buffer.sv
line_reader.sv
output_stage.sv
linemult_top.sv
tb_linemult.sv

/* lb_if.sv */
/*
  line buffer port bundle
  write port from the line writer, read port from the line reader
*/

interface lb_if;

  // write port
  logic                wr_en;
  linemult_pkg::page_t wr_page;
  linemult_pkg::hcnt_t wr_addr;
  linemult_pkg::rgb_t  wr_data;

  // read port, rd_data follows rd_en by one clock
  logic                rd_en;
  linemult_pkg::page_t rd_page;
  linemult_pkg::hcnt_t rd_addr;
  linemult_pkg::rgb_t  rd_data;

  modport writer (
    output wr_en,
    output wr_page,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_en,
    output rd_page,
    output rd_addr,
    input  rd_data
  );

  modport buffer (
    input  wr_en,
    input  wr_page,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_page,
    input  rd_addr,
    output rd_data
  );

endinterface

/* line_buffer.sv */
/*
  paged line buffer
  LM_NUM_PAGES pages of LM_LINE_MAX pixels, registered read port
*/

`include "linemult_defines.svh"

module line_buffer (
  input  logic VCLK_o,
  input  logic nVRST_o,
  lb_if.buffer lb
);

  localparam int ADDR_W = $clog2(`LM_LINE_MAX);

  linemult_pkg::rgb_t mem [`LM_NUM_PAGES][`LM_LINE_MAX];

  ////////////////////
  // write port

  always_ff @(posedge VCLK_o) begin
    if (lb.wr_en)
      mem[lb.wr_page][lb.wr_addr[ADDR_W-1:0]] <= lb.wr_data;
  end

  ////////////////////
  // read port, one clock latency

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      lb.rd_data <= '0;
    end else if (lb.rd_en) begin
      lb.rd_data <= mem[lb.rd_page][lb.rd_addr[ADDR_W-1:0]];
    end
  end

endmodule

/* line_reader.sv */
/*
  line reader
  plays every issued page twice at full clock rate, each copy behind a
  regenerated hsync pulse, and hands the page back after the second copy
*/

`include "linemult_defines.svh"

module line_reader (
  input  logic                VCLK_o,
  input  logic                nVRST_o,
  input  logic                line_ready_i,
  input  linemult_pkg::hcnt_t line_len_i,
  output logic                credit_return_o,
  lb_if.reader                lb,
  pix_if.source               pix
);

  localparam int HS_CNT_W = $clog2(`LM_HS_WIDTH);

  typedef enum logic [1:0] {PH_IDLE, PH_HSYNC, PH_READ} phase_t;

  phase_t                phase;
  logic                  copy;         // set while playing the second copy
  logic                  start;
  logic                  last;
  logic [HS_CNT_W-1:0]   hs_cnt;
  linemult_pkg::hcnt_t   rd_cnt;
  linemult_pkg::hcnt_t   cur_len;
  linemult_pkg::page_t   rd_page;
  linemult_pkg::page_t   len_idx;      // page of the next issued line
  linemult_pkg::credit_t pending;
  linemult_pkg::hcnt_t   len_tab [`LM_NUM_PAGES];

  assign start = (phase == PH_IDLE) && (pending != '0);
  assign last  = (phase == PH_READ) && (rd_cnt == cur_len - 1'b1);

  // line lengths, filled in issue order
  always_ff @(posedge VCLK_o) begin
    if (line_ready_i)
      len_tab[len_idx] <= line_len_i;
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      phase   <= PH_IDLE;
      copy    <= 1'b0;
      hs_cnt  <= '0;
      rd_cnt  <= '0;
      cur_len <= '0;
      rd_page <= '0;
      len_idx <= '0;
      pending <= '0;
    end else begin
      pending <= pending + linemult_pkg::credit_t'(line_ready_i) -
                 linemult_pkg::credit_t'(start);
      if (line_ready_i)
        len_idx <= (len_idx == linemult_pkg::page_t'(`LM_NUM_PAGES-1)) ? '0 : len_idx + 1'b1;

      case (phase)
        PH_IDLE: begin
          if (start) begin
            phase   <= PH_HSYNC;
            copy    <= 1'b0;
            hs_cnt  <= '0;
            cur_len <= len_tab[rd_page];
          end
        end
        PH_HSYNC: begin
          if (hs_cnt == HS_CNT_W'(`LM_HS_WIDTH-1)) begin
            phase  <= PH_READ;
            rd_cnt <= '0;
          end else begin
            hs_cnt <= hs_cnt + 1'b1;
          end
        end
        PH_READ: begin
          if (last) begin
            hs_cnt <= '0;
            if (!copy) begin
              phase <= PH_HSYNC;   // replay the same page
              copy  <= 1'b1;
            end else begin
              phase   <= PH_IDLE;
              rd_page <= (rd_page == linemult_pkg::page_t'(`LM_NUM_PAGES-1)) ? '0 : rd_page + 1'b1;
            end
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  assign lb.rd_en   = (phase == PH_READ);
  assign lb.rd_page = rd_page;
  assign lb.rd_addr = rd_cnt;

  ////////////////////
  // align the stream with the returning buffer data

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      pix.pix_valid   <= 1'b0;
      pix.pix_scan    <= 1'b0;
      pix.pix_nhs     <= 1'b1;
      credit_return_o <= 1'b0;
    end else begin
      pix.pix_valid   <= lb.rd_en;
      pix.pix_scan    <= lb.rd_en & copy;
      pix.pix_nhs     <= (phase != PH_HSYNC);
      credit_return_o <= last & copy;  // page is free again
    end
  end

  assign pix.pix_data = lb.rd_data;

endmodule

/* line_writer.sv */
/*
  line writer
  stores strobed pixels into the current buffer page and hands finished
  lines to the reader at the hsync falling edge, one credit per page
*/

`include "linemult_defines.svh"

module line_writer (
  input  logic                VCLK_o,
  input  logic                nVRST_o,
  input  logic                vdata_valid_i,
  input  logic                nhs_i,
  input  linemult_pkg::rgb_t  rgb_i,
  input  logic                linemult_en_i,
  input  logic                credit_return_i,
  output logic                line_ready_o,
  output linemult_pkg::hcnt_t line_len_o,
  lb_if.writer                lb
);

  logic                  nhs_q;
  logic                  nhs_fall;
  logic                  line_ok;      // line began while a page was free
  logic                  wr_take;
  logic                  issue;
  linemult_pkg::hcnt_t   wr_cnt;
  linemult_pkg::hcnt_t   wr_cnt_nxt;
  linemult_pkg::page_t   wr_page;
  linemult_pkg::credit_t credits;
  linemult_pkg::credit_t credits_nxt;

  assign nhs_fall = nhs_q & ~nhs_i;

  // pixels past the line cap are dropped
  assign wr_take    = linemult_en_i & line_ok & vdata_valid_i &
                      (wr_cnt != linemult_pkg::hcnt_t'(`LM_LINE_MAX));
  assign wr_cnt_nxt = wr_cnt + linemult_pkg::hcnt_t'(wr_take);

  assign issue = nhs_fall & linemult_en_i & line_ok & (wr_cnt_nxt != '0) &
                 (credits != '0);

  assign credits_nxt = credits - linemult_pkg::credit_t'(issue) +
                       linemult_pkg::credit_t'(credit_return_i);

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      nhs_q        <= 1'b1;
      line_ok      <= 1'b1;
      wr_cnt       <= '0;
      wr_page      <= '0;
      credits      <= linemult_pkg::credit_t'(`LM_NUM_PAGES);
      line_ready_o <= 1'b0;
      line_len_o   <= '0;
    end else begin
      nhs_q        <= nhs_i;
      credits      <= credits_nxt;
      line_ready_o <= issue;
      if (issue) begin
        line_len_o <= wr_cnt_nxt;
        wr_page    <= (wr_page == linemult_pkg::page_t'(`LM_NUM_PAGES-1)) ? '0 : wr_page + 1'b1;
      end
      // without a credit the page stays and the next line overwrites it
      if (nhs_fall || !linemult_en_i) begin
        wr_cnt  <= '0;
        line_ok <= (credits_nxt != '0);
      end else begin
        wr_cnt  <= wr_cnt_nxt;
      end
    end
  end

  assign lb.wr_en   = wr_take;
  assign lb.wr_page = wr_page;
  assign lb.wr_addr = wr_cnt;
  assign lb.wr_data = rgb_i;

endmodule

/* linemult_defines.svh */
/*
  line doubler configuration
  colour widths, buffer geometry and regenerated hsync length
*/

`ifndef LINEMULT_DEFINES_SVH
`define LINEMULT_DEFINES_SVH

// colour widths
`define LM_COLOR_W  7   // per colour at the input
`define LM_COLOR_OW 8   // per colour after widening

////////////////////
// line buffer geometry

`define LM_NUM_PAGES 4  // pages, also the initial credit count
`define LM_LINE_MAX  64 // stored pixels per line

////////////////////
// output timing

`define LM_HS_WIDTH 8   // low clocks of the regenerated hsync

`endif

/* linemult_pkg.sv */
/*
  line doubler types
  colours, pixels, line lengths, buffer pages and credit counts
*/

`include "linemult_defines.svh"

package linemult_pkg;

  typedef logic [`LM_COLOR_W-1:0] color_t;

  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } rgb_t;

  typedef struct packed {
    logic [`LM_COLOR_OW-1:0] r;
    logic [`LM_COLOR_OW-1:0] g;
    logic [`LM_COLOR_OW-1:0] b;
  } rgb_out_t;

  typedef logic [$clog2(`LM_LINE_MAX+1)-1:0]  hcnt_t;   // 0 .. LM_LINE_MAX
  typedef logic [$clog2(`LM_NUM_PAGES)-1:0]   page_t;
  typedef logic [$clog2(`LM_NUM_PAGES+1)-1:0] credit_t; // 0 .. LM_NUM_PAGES

endpackage

/* linemult_top.sv */
/*
  video line doubler
  paged line buffer with credit flow control, each line played twice
  with optional scanlines, or passed through when doubling is off
*/

`include "linemult_defines.svh"

module linemult_top (
  input  logic                    VCLK_o,
  input  logic                    nVRST_o,
  input  logic                    vdata_valid_i,
  input  logic                    nhs_i,
  input  logic [`LM_COLOR_W-1:0]  r_i,
  input  logic [`LM_COLOR_W-1:0]  g_i,
  input  logic [`LM_COLOR_W-1:0]  b_i,
  input  logic                    linemult_en_i,
  input  logic                    sl_en_i,
  input  logic [7:0]              sl_str_i,
  output logic                    vdata_valid_o,
  output logic                    nhs_o,
  output logic [`LM_COLOR_OW-1:0] r_o,
  output logic [`LM_COLOR_OW-1:0] g_o,
  output logic [`LM_COLOR_OW-1:0] b_o
);

  linemult_pkg::rgb_t     rgb_in;
  linemult_pkg::rgb_out_t rgb_out;
  logic                   line_ready;
  linemult_pkg::hcnt_t    line_len;
  logic                   credit_return;

  lb_if  lb ();
  pix_if pix ();

  assign rgb_in = '{r: r_i, g: g_i, b: b_i};

  line_writer i_line_writer (
    .VCLK_o          (VCLK_o),
    .nVRST_o         (nVRST_o),
    .vdata_valid_i   (vdata_valid_i),
    .nhs_i           (nhs_i),
    .rgb_i           (rgb_in),
    .linemult_en_i   (linemult_en_i),
    .credit_return_i (credit_return),
    .line_ready_o    (line_ready),
    .line_len_o      (line_len),
    .lb              (lb.writer)
  );

  line_buffer i_line_buffer (
    .VCLK_o  (VCLK_o),
    .nVRST_o (nVRST_o),
    .lb      (lb.buffer)
  );

  line_reader i_line_reader (
    .VCLK_o          (VCLK_o),
    .nVRST_o         (nVRST_o),
    .line_ready_i    (line_ready),
    .line_len_i      (line_len),
    .credit_return_o (credit_return),
    .lb              (lb.reader),
    .pix             (pix.source)
  );

  output_stage i_output_stage (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .pix           (pix.sink),
    .vdata_valid_i (vdata_valid_i),
    .nhs_i         (nhs_i),
    .rgb_i         (rgb_in),
    .linemult_en_i (linemult_en_i),
    .sl_en_i       (sl_en_i),
    .sl_str_i      (sl_str_i),
    .vdata_valid_o (vdata_valid_o),
    .nhs_o         (nhs_o),
    .rgb_o         (rgb_out)
  );

  assign r_o = rgb_out.r;
  assign g_o = rgb_out.g;
  assign b_o = rgb_out.b;

endmodule

/* output_stage.sv */
/*
  output stage
  picks bypass or doubled video, widens colours to 8 bits and darkens
  the second copy of a line as a scanline, two clocks on every path
*/

`include "linemult_defines.svh"

module output_stage (
  input  logic                   VCLK_o,
  input  logic                   nVRST_o,
  pix_if.sink                    pix,
  input  logic                   vdata_valid_i,
  input  logic                   nhs_i,
  input  linemult_pkg::rgb_t     rgb_i,
  input  logic                   linemult_en_i,
  input  logic                   sl_en_i,
  input  logic [7:0]             sl_str_i,
  output logic                   vdata_valid_o,
  output logic                   nhs_o,
  output linemult_pkg::rgb_out_t rgb_o
);

  // top bit repeated into the new lsb
  function automatic logic [`LM_COLOR_OW-1:0] widen(input linemult_pkg::color_t c);
    return {c, c[`LM_COLOR_W-1]};
  endfunction

  function automatic logic [`LM_COLOR_OW-1:0] shade(input logic [`LM_COLOR_OW-1:0] c,
                                                    input logic [7:0] str);
    logic [`LM_COLOR_OW+7:0] prod;
    prod = c * (8'd255 - str);
    return prod[`LM_COLOR_OW+7:8];
  endfunction

  logic                   sel_valid;
  logic                   sel_nhs;
  logic                   sel_scan;
  linemult_pkg::rgb_t     sel_rgb;
  logic                   s1_valid;
  logic                   s1_nhs;
  logic                   s1_scan;
  linemult_pkg::rgb_out_t s1_rgb;
  logic                   do_sl;

  always_comb begin
    if (linemult_en_i) begin
      sel_valid = pix.pix_valid;
      sel_nhs   = pix.pix_nhs;
      sel_scan  = pix.pix_scan;
      sel_rgb   = pix.pix_data;
    end else begin
      sel_valid = vdata_valid_i;  // bypass
      sel_nhs   = nhs_i;
      sel_scan  = 1'b0;
      sel_rgb   = rgb_i;
    end
  end

  assign do_sl = s1_scan & sl_en_i;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      s1_valid      <= 1'b0;
      s1_nhs        <= 1'b1;
      s1_scan       <= 1'b0;
      s1_rgb        <= '0;
      vdata_valid_o <= 1'b0;
      nhs_o         <= 1'b1;
      rgb_o         <= '0;
    end else begin
      // stage 1, select and widen
      s1_valid <= sel_valid;
      s1_nhs   <= sel_nhs;
      s1_scan  <= sel_scan & sel_valid;
      s1_rgb.r <= sel_valid ? widen(sel_rgb.r) : '0;
      s1_rgb.g <= sel_valid ? widen(sel_rgb.g) : '0;
      s1_rgb.b <= sel_valid ? widen(sel_rgb.b) : '0;
      // stage 2, scanline shading
      vdata_valid_o <= s1_valid;
      nhs_o         <= s1_nhs;
      rgb_o.r       <= do_sl ? shade(s1_rgb.r, sl_str_i) : s1_rgb.r;
      rgb_o.g       <= do_sl ? shade(s1_rgb.g, sl_str_i) : s1_rgb.g;
      rgb_o.b       <= do_sl ? shade(s1_rgb.b, sl_str_i) : s1_rgb.b;
    end
  end

endmodule

/* pix_if.sv */
/*
  played-back pixel stream
  reader to output stage, all fields aligned to the same clock
*/

interface pix_if;

  logic               pix_valid;
  linemult_pkg::rgb_t pix_data;
  logic               pix_scan;  // pixel of the second copy
  logic               pix_nhs;   // regenerated hsync, active low

  modport source (
    output pix_valid,
    output pix_data,
    output pix_scan,
    output pix_nhs
  );

  modport sink (
    input pix_valid,
    input pix_data,
    input pix_scan,
    input pix_nhs
  );

endinterface

/* tb_linemult.sv */
/*
  testbench for the line doubler
  directed tests covering idle state, bypass, doubling, scanlines,
  the line length cap and dropped lines under back-pressure
*/

`include "linemult_defines.svh"

module tb_linemult;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS = 10;
  localparam int QUIET  = 100;  // idle output cycles that close a test
  localparam int PIX_W  = 3 * `LM_COLOR_W;
  localparam int OPIX_W = 3 * `LM_COLOR_OW;

  // rough length of each test in clock cycles
  localparam int LEN_IDLE    = 40;
  localparam int LEN_BYPASS  = 80;
  localparam int LEN_DOUBLE  = 700;
  localparam int LEN_SCAN    = 1500;
  localparam int LEN_CAP     = 500;
  localparam int LEN_BURST   = 600;
  localparam int WATCHDOG_NS = 2 * CLK_NS *
    (LEN_IDLE + LEN_BYPASS + LEN_DOUBLE + LEN_SCAN + LEN_CAP + LEN_BURST);

  logic                    VCLK_o = 1'b0;
  logic                    nVRST_o;
  logic                    vdata_valid_i;
  logic                    nhs_i;
  logic [`LM_COLOR_W-1:0]  r_i;
  logic [`LM_COLOR_W-1:0]  g_i;
  logic [`LM_COLOR_W-1:0]  b_i;
  logic                    linemult_en_i;
  logic                    sl_en_i;
  logic [7:0]              sl_str_i;
  logic                    vdata_valid_o;
  logic                    nhs_o;
  logic [`LM_COLOR_OW-1:0] r_o;
  logic [`LM_COLOR_OW-1:0] g_o;
  logic [`LM_COLOR_OW-1:0] b_o;

  integer seed = 2938;
  string  cur_test = "none";

  // input lines and collected output lines, stored flat
  logic [PIX_W-1:0]  in_pix [$];
  int                in_start [$];
  int                in_len [$];
  logic [OPIX_W-1:0] out_pix [$];
  int                out_start [$];
  int                out_len [$];

  bit prev_nhs;
  bit line_open;
  int hs_cnt;
  int pix_cnt;
  int quiet_cnt;

  linemult_top i_linemult_top (.*);

  always #(CLK_NS / 2) VCLK_o = ~VCLK_o;

  ////////////////////
  // error reporting

  task automatic report_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_plain(input string msg);
    $display("** Error [%s] %s", cur_test, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("** Error: watchdog expired, the tests did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////
  // reference model

  // widen by repeating the top bit, then darken if it is a scanline pixel
  function automatic logic [OPIX_W-1:0] expected_pixel(input logic [PIX_W-1:0] px,
                                                       input bit scan, input int str);
    logic [OPIX_W-1:0] res;
    int                c;
    int                k;
    for (k = 0; k < 3; k++) begin
      c = px[`LM_COLOR_W*k +: `LM_COLOR_W];
      c = 2 * c + (c >> (`LM_COLOR_W - 1));
      if (scan)
        c = (c * (255 - str)) / 256;
      res[`LM_COLOR_OW*k +: `LM_COLOR_OW] = c[`LM_COLOR_OW-1:0];
    end
    return res;
  endfunction

  function automatic bit line_equal(input int i, input int j);
    int p;
    if (out_len[j] != in_len[i])
      return 1'b0;
    for (p = 0; p < in_len[i]; p++) begin
      if (out_pix[out_start[j] + p] != expected_pixel(in_pix[in_start[i] + p], 1'b0, 0))
        return 1'b0;
    end
    return 1'b1;
  endfunction

  ////////////////////
  // output line collector, doubling mode only

  task automatic close_line();
    out_start.push_back(out_pix.size() - pix_cnt);
    out_len.push_back(pix_cnt);
    pix_cnt   = 0;
    line_open = 1'b0;
  endtask

  always @(negedge VCLK_o) begin
    if (nVRST_o && linemult_en_i) begin
      if (!nhs_o) begin
        if (prev_nhs) begin  // falling edge opens a line
          if (pix_cnt != 0)
            close_line();
          line_open = 1'b1;
          hs_cnt    = 0;
        end
        hs_cnt++;
        assert (!vdata_valid_o) else report_plain("valid pixel during the output hsync");
      end else if (vdata_valid_o) begin
        assert (line_open) else report_plain("output pixel without a leading hsync");
        if (pix_cnt == 0) begin
          assert (hs_cnt == `LM_HS_WIDTH) else report_value("hsync width", `LM_HS_WIDTH, hs_cnt);
        end
        out_pix.push_back({r_o, g_o, b_o});
        pix_cnt++;
      end else if (pix_cnt != 0) begin
        close_line();
      end else if (line_open) begin
        report_plain("gap between the output hsync and the first pixel");
      end
      prev_nhs = nhs_o;
      if (!nhs_o || vdata_valid_o)
        quiet_cnt = 0;
      else
        quiet_cnt++;
    end
  end

  ////////////////////
  // stimulus helpers

  task automatic drive_idle();
    vdata_valid_i = 1'b0;
    nhs_i         = 1'b1;
    {r_i, g_i, b_i} = '0;
  endtask

  // configuration changes only while reset is held
  task automatic apply_reset(input bit en, input bit sl_en, input int str);
    @(posedge VCLK_o);
    #1;
    nVRST_o       = 1'b0;
    linemult_en_i = en;
    sl_en_i       = sl_en;
    sl_str_i      = str[7:0];
    drive_idle();
    in_pix.delete();
    in_start.delete();
    in_len.delete();
    out_pix.delete();
    out_start.delete();
    out_len.delete();
    prev_nhs  = 1'b1;
    line_open = 1'b0;
    hs_cnt    = 0;
    pix_cnt   = 0;
    repeat (5) @(posedge VCLK_o);
    #1;
    nVRST_o = 1'b1;
  endtask

  // n strobed pixels, blank high cycles, then hs_len low cycles end the line
  task automatic send_line(input int n, input int blank, input int hs_len);
    int               i;
    int               rnd;
    logic [PIX_W-1:0] px;
    in_start.push_back(in_pix.size());
    in_len.push_back(n);
    for (i = 0; i < n; i++) begin
      rnd = $random(seed);
      px  = rnd[PIX_W-1:0];
      in_pix.push_back(px);
      @(posedge VCLK_o);
      #1;
      vdata_valid_i   = 1'b1;
      {r_i, g_i, b_i} = px;
      @(posedge VCLK_o);
      #1;
      vdata_valid_i = 1'b0;
    end
    repeat (blank) @(posedge VCLK_o);
    #1;
    nhs_i = 1'b0;
    repeat (hs_len) @(posedge VCLK_o);
    #1;
    nhs_i = 1'b1;
  endtask

  task automatic wait_quiet();
    quiet_cnt = 0;
    while (quiet_cnt < QUIET)
      @(negedge VCLK_o);
  endtask

  // every input line twice, second copy shaded when scanlines are on
  task automatic check_doubled(input bit scan_en, input int str);
    int                i;
    int                cp;
    int                j;
    int                n;
    int                p;
    logic [OPIX_W-1:0] exp;
    assert (out_len.size() == 2 * in_len.size())
      else report_value("output line count", 2 * in_len.size(), out_len.size());
    for (i = 0; i < in_len.size(); i++) begin
      n = (in_len[i] > `LM_LINE_MAX) ? `LM_LINE_MAX : in_len[i];
      for (cp = 0; cp < 2; cp++) begin
        j = 2 * i + cp;
        assert (out_len[j] == n) else report_value("line length", n, out_len[j]);
        for (p = 0; p < n; p++) begin
          exp = expected_pixel(in_pix[in_start[i] + p], scan_en && (cp == 1), str);
          assert (out_pix[out_start[j] + p] == exp)
            else report_value("pixel", exp, out_pix[out_start[j] + p]);
        end
      end
    end
  endtask

  ////////////////////
  // tests

  task automatic test_idle();
    cur_test = "idle";
    apply_reset(1'b1, 1'b0, 0);
    repeat (30) begin
      @(negedge VCLK_o);
      assert (!vdata_valid_o && nhs_o) else report_plain("outputs active with no input");
      assert ({r_o, g_o, b_o} == '0) else report_value("idle colour", 0, {r_o, g_o, b_o});
    end
  endtask

  task automatic test_bypass();
    logic [PIX_W+1:0]  hist [$];  // {valid, nhs, rgb} per cycle
    logic [PIX_W+1:0]  cur;
    logic [PIX_W+1:0]  old;
    logic [OPIX_W-1:0] exp;
    int                c;
    int                rnd;
    cur_test = "bypass";
    apply_reset(1'b0, 1'b0, 0);
    for (c = 0; c < 42; c++) begin
      @(posedge VCLK_o);
      #1;
      if (c >= 2) begin
        old = hist[c-2];
        exp = old[PIX_W+1] ? expected_pixel(old[PIX_W-1:0], 1'b0, 0) : '0;
        assert (vdata_valid_o == old[PIX_W+1])
          else report_value("vdata_valid_o", old[PIX_W+1], vdata_valid_o);
        assert (nhs_o == old[PIX_W]) else report_value("nhs_o", old[PIX_W], nhs_o);
        assert ({r_o, g_o, b_o} == exp) else report_value("pixel", exp, {r_o, g_o, b_o});
      end
      rnd = $random(seed);
      cur = (c < 40) ? rnd[PIX_W+1:0] : {1'b0, 1'b1, {PIX_W{1'b0}}};
      hist.push_back(cur);
      vdata_valid_i   = cur[PIX_W+1];
      nhs_i           = cur[PIX_W];
      {r_i, g_i, b_i} = cur[PIX_W-1:0];
    end
    drive_idle();
  endtask

  task automatic test_double();
    cur_test = "double";
    apply_reset(1'b1, 1'b0, 0);
    send_line(1, 20, 10);
    send_line(5, 20, 10);
    send_line(17, 20, 10);
    send_line(`LM_LINE_MAX, 20, 10);
    wait_quiet();
    check_doubled(1'b0, 0);
  endtask

  task automatic test_scanlines();
    int strength [3] = '{0, 128, 255};
    int s;
    for (s = 0; s < 3; s++) begin
      cur_test = $sformatf("scanline %0d", strength[s]);
      apply_reset(1'b1, 1'b1, strength[s]);
      send_line(20, 20, 10);
      send_line(9, 20, 10);
      wait_quiet();
      check_doubled(1'b1, strength[s]);
    end
  endtask

  task automatic test_line_cap();
    cur_test = "line cap";
    apply_reset(1'b1, 1'b0, 0);
    send_line(`LM_LINE_MAX + 6, 20, 10);
    send_line(3, 20, 10);
    wait_quiet();
    check_doubled(1'b0, 0);
  endtask

  // short lines arrive faster than they play back, so some are dropped
  task automatic test_burst();
    int j;
    int k;
    cur_test = "burst";
    apply_reset(1'b1, 1'b0, 0);
    repeat (12) send_line(4, 1, 1);
    wait_quiet();
    assert ((out_len.size() % 2 == 0) && (out_len.size() >= 2 * `LM_NUM_PAGES))
      else report_value("output line count", 2 * `LM_NUM_PAGES, out_len.size());
    k = 0;
    for (j = 0; j < out_len.size(); j += 2) begin
      while ((k < in_len.size()) && !line_equal(k, j))
        k++;
      assert (k < in_len.size()) else report_plain("output line is not an in-order input line");
      assert (line_equal(k, j + 1)) else report_plain("second copy differs from its input line");
      if (j / 2 < `LM_NUM_PAGES) begin
        assert (k == j / 2) else report_value("early line index", j / 2, k);
      end
      k++;
    end
  endtask

  initial begin
    nVRST_o       = 1'b0;
    linemult_en_i = 1'b0;
    sl_en_i       = 1'b0;
    sl_str_i      = '0;
    drive_idle();
    test_idle();
    test_bypass();
    test_double();
    test_scanlines();
    test_line_cap();
    test_burst();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
